//--- core_mem_wrapper.f
logic/mem_pkg.sv
logic/bootrom.sv
logic/fetch_refill.sv
logic/amo_unit.sv
logic/mem_arbiter.sv
logic/core_mem_wrapper.sv
tb/core_mem_wrapper_props.sv
tb/tb_core_mem_wrapper.sv

//--- tb/tb_core_mem_wrapper.sv
`timescale 1ns/1ps

module tb_core_mem_wrapper;

    import mem_pkg::*;

    localparam int LINE_BEATS = 4;
    localparam int LINE_BYTES = LINE_BEATS * 4;
    localparam int MEM_WORDS  = 256;
    localparam int MAX_DELAY  = 6;
    localparam int N_FETCH    = 12;
    localparam int N_DATA     = 40;
    localparam int N_AMO      = 30;
    localparam int N_CONC     = 16;
    localparam int N_OPS      = BOOT_LIMIT / LINE_BYTES + N_FETCH + N_DATA + N_AMO + 2 * N_CONC;
    // Every op takes at most LINE_BEATS bus transactions, each bounded by delay plus stalls
    localparam longint WATCHDOG_NS =
        longint'(N_OPS) * LINE_BEATS * (MAX_DELAY + 4) * 20 * 3;

    logic                          clk_i = 1'b0;
    logic                          rst_n_i;
    logic                          fetch_valid_i;
    logic                          fetch_ready_o;
    logic [ADDR_W-1:0]             fetch_paddr_i;
    logic                          fetch_resp_valid_o;
    logic [DATA_W-1:0]             fetch_resp_data_o;
    logic [$clog2(LINE_BEATS)-1:0] fetch_resp_beat_o;
    logic                          dreq_valid_i;
    logic                          dreq_ready_o;
    mem_op_e                       dreq_op_i;
    logic [ADDR_W-1:0]             dreq_addr_i;
    logic [DATA_W-1:0]             dreq_wdata_i;
    logic                          dresp_valid_o;
    logic [DATA_W-1:0]             dresp_rdata_o;
    logic                          mem_req_valid_o;
    logic                          mem_req_ready_i;
    logic                          mem_req_we_o;
    logic [ADDR_W-1:0]             mem_req_addr_o;
    logic [DATA_W-1:0]             mem_req_wdata_o;
    logic                          mem_resp_valid_i;
    logic [DATA_W-1:0]             mem_resp_rdata_i;

    // Bus memory and the shadow copy seen by the data reference model
    logic [DATA_W-1:0] mem    [MEM_WORDS];
    logic [DATA_W-1:0] shadow [MEM_WORDS];

    int seed     = 32'h278c_d85f;
    int bus_seed = ~32'h278c_d85f;
    int errors   = 0;
    int checks   = 0;

    logic              pend = 1'b0;
    logic              pend_we;
    logic [ADDR_W-1:0] pend_addr;
    logic [DATA_W-1:0] pend_wdata;
    int                pend_delay;

    core_mem_wrapper #(
        .LINE_BEATS (LINE_BEATS)
    ) UUT (.*);

    always #10 clk_i = ~clk_i;

    function automatic logic [DATA_W-1:0] fill_word(input int idx);
        return (idx * 32'h9e37_79b9) ^ 32'h5a5a_0000 ^ idx;
    endfunction

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Memory value after an op, per opcode rule
    function automatic logic [DATA_W-1:0] apply_rule(
        input mem_op_e           op,
        input logic [DATA_W-1:0] old_v,
        input logic [DATA_W-1:0] opnd
    );
        case (op)
            OP_LOAD:     return old_v;
            OP_STORE:    return opnd;
            OP_AMO_ADD:  return old_v + opnd;
            OP_AMO_SWAP: return opnd;
            OP_AMO_AND:  return old_v & opnd;
            OP_AMO_OR:   return old_v | opnd;
            default:     return ($signed(old_v) > $signed(opnd)) ? old_v : opnd;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        checks++;
        if (exp_v !== act_v) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp_v, act_v);
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        $display("%-12s finished with %0d errors", name, errors - err_start);
    endtask

    task automatic fetch_line(input string name, input logic [ADDR_W-1:0] addr);
        int               beat;
        int               wait_cyc;
        int               base;
        bit               boot;
        logic [DATA_W-1:0] exp_v;
        boot = (addr < BOOT_LIMIT);
        base = int'(addr >> 2);
        @(negedge clk_i);
        fetch_valid_i = 1'b1;
        fetch_paddr_i = addr;
        do @(posedge clk_i); while (!fetch_ready_o);
        @(negedge clk_i);
        fetch_valid_i = 1'b0;
        wait_cyc = 0;
        beat = 0;
        while (beat < LINE_BEATS) begin
            @(posedge clk_i);
            wait_cyc++;
            if (fetch_resp_valid_o) begin
                // ROM beats follow acceptance by 2 cycles, then one per cycle
                if (boot) begin
                    check_value({name, " latency"}, 2 + beat, wait_cyc);
                end
                exp_v = boot ? BOOT_IMAGE[base + beat] : mem[base + beat];
                check_value({name, " beat"}, beat, fetch_resp_beat_o);
                check_value({name, " data"}, exp_v, fetch_resp_data_o);
                beat++;
            end
        end
    endtask

    task automatic data_access(input string name, input mem_op_e op,
                               input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
        int                idx;
        logic [DATA_W-1:0] old_v;
        logic [DATA_W-1:0] exp_v;
        idx = int'(addr >> 2);
        old_v = shadow[idx];
        exp_v = (op == OP_STORE) ? '0 : old_v;
        shadow[idx] = apply_rule(op, old_v, wdata);
        @(negedge clk_i);
        dreq_valid_i = 1'b1;
        dreq_op_i    = op;
        dreq_addr_i  = addr;
        dreq_wdata_i = wdata;
        do @(posedge clk_i); while (!dreq_ready_o);
        @(negedge clk_i);
        dreq_valid_i = 1'b0;
        do @(posedge clk_i); while (!dresp_valid_o);
        check_value({name, " ", op.name()}, exp_v, dresp_rdata_o);
    endtask

    // Bus model: capture on the rising edge, answer on the falling edge
    always @(posedge clk_i) begin
        if (mem_req_valid_o && mem_req_ready_i) begin
            pend       = 1'b1;
            pend_we    = mem_req_we_o;
            pend_addr  = mem_req_addr_o;
            pend_wdata = mem_req_wdata_o;
            pend_delay = int'($unsigned($random(bus_seed)) % (MAX_DELAY + 1));
        end
    end

    always @(negedge clk_i) begin
        mem_req_ready_i  = ($unsigned($random(bus_seed)) % 4) != 0;
        mem_resp_valid_i = 1'b0;
        mem_resp_rdata_i = '0;
        if (pend) begin
            if (pend_delay == 0) begin
                mem_resp_valid_i = 1'b1;
                if (pend_we) begin
                    mem[pend_addr[9:2]] = pend_wdata;
                end else begin
                    mem_resp_rdata_i = mem[pend_addr[9:2]];
                end
                pend = 1'b0;
            end else begin
                pend_delay--;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not complete within %0d ns", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        int                err_start;
        mem_op_e           op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        rst_n_i          = 1'b0;
        fetch_valid_i    = 1'b0;
        fetch_paddr_i    = '0;
        dreq_valid_i     = 1'b0;
        dreq_op_i        = OP_LOAD;
        dreq_addr_i      = '0;
        dreq_wdata_i     = '0;
        mem_req_ready_i  = 1'b0;
        mem_resp_valid_i = 1'b0;
        mem_resp_rdata_i = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]    = fill_word(i);
            shadow[i] = mem[i];
        end
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        err_start = errors;
        @(posedge clk_i);
        check_value("reset fetch_resp_valid", 0, fetch_resp_valid_o);
        check_value("reset dresp_valid", 0, dresp_valid_o);
        check_value("reset mem_req_valid", 0, mem_req_valid_o);
        check_value("reset fetch_ready", 1, fetch_ready_o);
        check_value("reset dreq_ready", 1, dreq_ready_o);
        report_test("reset", err_start);

        err_start = errors;
        for (int i = 0; i < BOOT_LIMIT / LINE_BYTES; i++) begin
            fetch_line("boot_fetch", i * LINE_BYTES);
        end
        report_test("boot_fetch", err_start);

        err_start = errors;
        for (int i = 0; i < N_FETCH; i++) begin
            addr = BOOT_LIMIT + rand_below((512 - BOOT_LIMIT) / LINE_BYTES) * LINE_BYTES;
            fetch_line("bus_fetch", addr);
        end
        report_test("bus_fetch", err_start);

        // Data accesses stay in the upper half, clear of fetched lines
        err_start = errors;
        for (int i = 0; i < N_DATA; i++) begin
            op    = mem_op_e'(rand_below(2));
            addr  = 512 + rand_below(16) * 4;
            wdata = $random(seed);
            data_access("load_store", op, addr, wdata);
        end
        report_test("load_store", err_start);

        err_start = errors;
        for (int k = int'(OP_AMO_ADD); k <= int'(OP_AMO_MAX); k++) begin
            repeat (N_AMO / 10) begin
                addr  = 512 + rand_below(16) * 4;
                wdata = $random(seed);
                data_access("amo", mem_op_e'(k), addr, wdata);
                data_access("amo_readback", OP_LOAD, addr, '0);
            end
        end
        report_test("amo", err_start);

        err_start = errors;
        fork
            for (int i = 0; i < N_CONC; i++) begin
                fetch_line("conc_fetch", ((i * 7) % (512 / LINE_BYTES)) * LINE_BYTES);
            end
            begin : data_stream
                mem_op_e           c_op;
                logic [ADDR_W-1:0] c_addr;
                logic [DATA_W-1:0] c_wdata;
                for (int i = 0; i < N_CONC; i++) begin
                    c_op    = mem_op_e'(rand_below(7));
                    c_addr  = 512 + rand_below(16) * 4;
                    c_wdata = $random(seed);
                    data_access("conc_data", c_op, c_addr, c_wdata);
                end
            end
        join
        report_test("concurrent", err_start);

        $display("Tests: 6, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- tb/core_mem_wrapper_props.sv
`timescale 1ns/1ps

module core_mem_wrapper_props (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       lock_i,
    input  logic                       req_valid_i,
    input  logic                       req_ready_i,
    input  logic                       req_we_i,
    input  logic [mem_pkg::ADDR_W-1:0] req_addr_i,
    input  logic [mem_pkg::DATA_W-1:0] req_wdata_i,
    input  logic                       resp_valid_i,
    input  logic                       idle_ready_i
);

    logic outstanding_q;

    // One accepted request until its response
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            outstanding_q <= 1'b0;
        end else if (req_valid_i && req_ready_i) begin
            outstanding_q <= 1'b1;
        end else if (resp_valid_i) begin
            outstanding_q <= 1'b0;
        end
    end

    // The atomic owns the bus between its read and its write
    lock_blocks_fetch: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        lock_i && req_valid_i |-> req_we_i)
        else $error("read request issued while the lock is held");

    stall_keeps_fields: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_we_i) &&
            $stable(req_addr_i) && $stable(req_wdata_i))
        else $error("request changed while the bus stalled");

    single_outstanding: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        outstanding_q |-> !(req_valid_i && req_ready_i))
        else $error("second request accepted while one is outstanding");

    resp_only_when_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        resp_valid_i |-> outstanding_q)
        else $error("response arrived with nothing outstanding");

    ready_after_reset: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> idle_ready_i)
        else $error("not ready in the first cycle after reset");

endmodule

bind mem_arbiter core_mem_wrapper_props u_arb_props (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .lock_i        (lock_i),
    .req_valid_i   (mem_req_valid_o),
    .req_ready_i   (mem_req_ready_i),
    .req_we_i      (mem_req_we_o),
    .req_addr_i    (mem_req_addr_o),
    .req_wdata_i   (mem_req_wdata_o),
    .resp_valid_i  (mem_resp_valid_i),
    .idle_ready_i  (!busy_q)
);

bind amo_unit core_mem_wrapper_props u_amo_props (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .lock_i        (lock_o),
    .req_valid_i   (bus_valid_o),
    .req_ready_i   (bus_ready_i),
    .req_we_i      (bus_we_o),
    .req_addr_i    (bus_addr_o),
    .req_wdata_i   (bus_wdata_o),
    .resp_valid_i  (bus_resp_valid_i),
    .idle_ready_i  (dreq_ready_o)
);

//--- logic/core_mem_wrapper.sv
`timescale 1ns/1ps

module core_mem_wrapper #(
    parameter int LINE_BEATS = 4
) (
    input  logic                          clk_i,
    input  logic                          rst_n_i,

    input  logic                          fetch_valid_i,
    output logic                          fetch_ready_o,
    input  logic [mem_pkg::ADDR_W-1:0]    fetch_paddr_i,
    output logic                          fetch_resp_valid_o,
    output logic [mem_pkg::DATA_W-1:0]    fetch_resp_data_o,
    output logic [$clog2(LINE_BEATS)-1:0] fetch_resp_beat_o,

    input  logic                          dreq_valid_i,
    output logic                          dreq_ready_o,
    input  mem_pkg::mem_op_e              dreq_op_i,
    input  logic [mem_pkg::ADDR_W-1:0]    dreq_addr_i,
    input  logic [mem_pkg::DATA_W-1:0]    dreq_wdata_i,
    output logic                          dresp_valid_o,
    output logic [mem_pkg::DATA_W-1:0]    dresp_rdata_o,

    output logic                          mem_req_valid_o,
    input  logic                          mem_req_ready_i,
    output logic                          mem_req_we_o,
    output logic [mem_pkg::ADDR_W-1:0]    mem_req_addr_o,
    output logic [mem_pkg::DATA_W-1:0]    mem_req_wdata_o,
    input  logic                          mem_resp_valid_i,
    input  logic [mem_pkg::DATA_W-1:0]    mem_resp_rdata_i
);

    import mem_pkg::*;

    // Fetch path to arbiter
    logic              fetch_bus_valid;
    logic              fetch_bus_ready;
    logic [ADDR_W-1:0] fetch_bus_addr;
    logic              fetch_bus_resp_valid;
    logic [DATA_W-1:0] fetch_bus_resp_rdata;

    // Data path to arbiter
    logic              amo_bus_valid;
    logic              amo_bus_ready;
    logic              amo_bus_we;
    logic [ADDR_W-1:0] amo_bus_addr;
    logic [DATA_W-1:0] amo_bus_wdata;
    logic              amo_bus_resp_valid;
    logic [DATA_W-1:0] amo_bus_resp_rdata;
    logic              amo_lock;

    fetch_refill #(
        .LINE_BEATS (LINE_BEATS)
    ) u_fetch_refill (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .fetch_valid_i      (fetch_valid_i),
        .fetch_ready_o      (fetch_ready_o),
        .fetch_paddr_i      (fetch_paddr_i),
        .fetch_resp_valid_o (fetch_resp_valid_o),
        .fetch_resp_data_o  (fetch_resp_data_o),
        .fetch_resp_beat_o  (fetch_resp_beat_o),
        .bus_valid_o        (fetch_bus_valid),
        .bus_ready_i        (fetch_bus_ready),
        .bus_addr_o         (fetch_bus_addr),
        .bus_resp_valid_i   (fetch_bus_resp_valid),
        .bus_resp_rdata_i   (fetch_bus_resp_rdata)
    );

    amo_unit u_amo_unit (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .dreq_valid_i     (dreq_valid_i),
        .dreq_ready_o     (dreq_ready_o),
        .dreq_op_i        (dreq_op_i),
        .dreq_addr_i      (dreq_addr_i),
        .dreq_wdata_i     (dreq_wdata_i),
        .dresp_valid_o    (dresp_valid_o),
        .dresp_rdata_o    (dresp_rdata_o),
        .bus_valid_o      (amo_bus_valid),
        .bus_ready_i      (amo_bus_ready),
        .bus_we_o         (amo_bus_we),
        .bus_addr_o       (amo_bus_addr),
        .bus_wdata_o      (amo_bus_wdata),
        .bus_resp_valid_i (amo_bus_resp_valid),
        .bus_resp_rdata_i (amo_bus_resp_rdata),
        .lock_o           (amo_lock)
    );

    mem_arbiter u_mem_arbiter (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .fetch_valid_i      (fetch_bus_valid),
        .fetch_ready_o      (fetch_bus_ready),
        .fetch_addr_i       (fetch_bus_addr),
        .fetch_resp_valid_o (fetch_bus_resp_valid),
        .fetch_resp_rdata_o (fetch_bus_resp_rdata),
        .data_valid_i       (amo_bus_valid),
        .data_ready_o       (amo_bus_ready),
        .data_we_i          (amo_bus_we),
        .data_addr_i        (amo_bus_addr),
        .data_wdata_i       (amo_bus_wdata),
        .data_resp_valid_o  (amo_bus_resp_valid),
        .data_resp_rdata_o  (amo_bus_resp_rdata),
        .lock_i             (amo_lock),
        .mem_req_valid_o    (mem_req_valid_o),
        .mem_req_ready_i    (mem_req_ready_i),
        .mem_req_we_o       (mem_req_we_o),
        .mem_req_addr_o     (mem_req_addr_o),
        .mem_req_wdata_o    (mem_req_wdata_o),
        .mem_resp_valid_i   (mem_resp_valid_i),
        .mem_resp_rdata_i   (mem_resp_rdata_i)
    );

endmodule

//--- logic/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                       clk_i,
    input  logic                       rst_n_i,

    // Fetch side, reads only
    input  logic                       fetch_valid_i,
    output logic                       fetch_ready_o,
    input  logic [mem_pkg::ADDR_W-1:0] fetch_addr_i,
    output logic                       fetch_resp_valid_o,
    output logic [mem_pkg::DATA_W-1:0] fetch_resp_rdata_o,

    // Data side
    input  logic                       data_valid_i,
    output logic                       data_ready_o,
    input  logic                       data_we_i,
    input  logic [mem_pkg::ADDR_W-1:0] data_addr_i,
    input  logic [mem_pkg::DATA_W-1:0] data_wdata_i,
    output logic                       data_resp_valid_o,
    output logic [mem_pkg::DATA_W-1:0] data_resp_rdata_o,
    input  logic                       lock_i,

    // Outward memory bus
    output logic                       mem_req_valid_o,
    input  logic                       mem_req_ready_i,
    output logic                       mem_req_we_o,
    output logic [mem_pkg::ADDR_W-1:0] mem_req_addr_o,
    output logic [mem_pkg::DATA_W-1:0] mem_req_wdata_o,
    input  logic                       mem_resp_valid_i,
    input  logic [mem_pkg::DATA_W-1:0] mem_resp_rdata_i
);

    logic busy_q;
    logic owner_data_q;
    logic last_data_q;
    logic hold_q;
    logic hold_data_q;
    logic pick_data;
    logic grant_fetch;
    logic grant_data;
    logic accept;

    always_comb begin
        pick_data = 1'b0;
        if (lock_i) begin
            pick_data = 1'b1;
        end else if (hold_q) begin
            // Keep a stalled request on the bus unchanged
            pick_data = hold_data_q;
        end else if (fetch_valid_i && data_valid_i) begin
            pick_data = !last_data_q;
        end else begin
            pick_data = data_valid_i;
        end
    end

    assign grant_data  = !busy_q && pick_data && data_valid_i;
    assign grant_fetch = !busy_q && !pick_data && fetch_valid_i;
    assign accept      = mem_req_valid_o && mem_req_ready_i;

    assign mem_req_valid_o = grant_fetch || grant_data;
    assign mem_req_we_o    = grant_data && data_we_i;
    assign mem_req_addr_o  = grant_data ? data_addr_i : fetch_addr_i;
    assign mem_req_wdata_o = grant_data ? data_wdata_i : '0;

    assign fetch_ready_o = grant_fetch && mem_req_ready_i;
    assign data_ready_o  = grant_data && mem_req_ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q       <= 1'b0;
            owner_data_q <= 1'b0;
            last_data_q  <= 1'b0;
            hold_q       <= 1'b0;
            hold_data_q  <= 1'b0;
        end else begin
            hold_q      <= mem_req_valid_o && !mem_req_ready_i;
            hold_data_q <= grant_data;
            if (accept) begin
                busy_q       <= 1'b1;
                owner_data_q <= grant_data;
                // Rotate priority only when both sides competed
                if (fetch_valid_i && data_valid_i) begin
                    last_data_q <= grant_data;
                end
            end else if (mem_resp_valid_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Route the single outstanding response to its issuer
    assign fetch_resp_valid_o = mem_resp_valid_i && busy_q && !owner_data_q;
    assign data_resp_valid_o  = mem_resp_valid_i && busy_q && owner_data_q;
    assign fetch_resp_rdata_o = mem_resp_rdata_i;
    assign data_resp_rdata_o  = mem_resp_rdata_i;

endmodule

//--- logic/amo_unit.sv
`timescale 1ns/1ps

module amo_unit (
    input  logic                       clk_i,
    input  logic                       rst_n_i,

    // Data request from the core
    input  logic                       dreq_valid_i,
    output logic                       dreq_ready_o,
    input  mem_pkg::mem_op_e           dreq_op_i,
    input  logic [mem_pkg::ADDR_W-1:0] dreq_addr_i,
    input  logic [mem_pkg::DATA_W-1:0] dreq_wdata_i,
    output logic                       dresp_valid_o,
    output logic [mem_pkg::DATA_W-1:0] dresp_rdata_o,

    // Requester port towards the arbiter
    output logic                       bus_valid_o,
    input  logic                       bus_ready_i,
    output logic                       bus_we_o,
    output logic [mem_pkg::ADDR_W-1:0] bus_addr_o,
    output logic [mem_pkg::DATA_W-1:0] bus_wdata_o,
    input  logic                       bus_resp_valid_i,
    input  logic [mem_pkg::DATA_W-1:0] bus_resp_rdata_i,
    output logic                       lock_o
);

    import mem_pkg::*;

    amo_state_e          state_q;
    mem_op_e             op_q;
    logic [ADDR_W-1:0]   addr_q;
    logic [DATA_W-1:0]   operand_q;
    logic [DATA_W-1:0]   old_q;
    logic [DATA_W-1:0]   new_q;
    logic                is_amo;

    // New memory value for a read-modify-write
    function automatic logic [DATA_W-1:0] amo_apply(
        input mem_op_e           op,
        input logic [DATA_W-1:0] old_val,
        input logic [DATA_W-1:0] opnd
    );
        logic [DATA_W-1:0] res;
        case (op)
            OP_AMO_ADD:  res = old_val + opnd;
            OP_AMO_SWAP: res = opnd;
            OP_AMO_AND:  res = old_val & opnd;
            OP_AMO_OR:   res = old_val | opnd;
            OP_AMO_MAX:  res = ($signed(old_val) > $signed(opnd)) ? old_val : opnd;
            default:     res = old_val;
        endcase
        return res;
    endfunction

    assign is_amo = (op_q != OP_LOAD) && (op_q != OP_STORE);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= A_IDLE;
            op_q    <= OP_LOAD;
        end else begin
            case (state_q)
                A_IDLE: begin
                    if (dreq_valid_i) begin
                        op_q    <= dreq_op_i;
                        state_q <= (dreq_op_i == OP_STORE) ? A_WRITE_REQ : A_READ_REQ;
                    end
                end
                A_READ_REQ:   if (bus_ready_i) state_q <= A_READ_WAIT;
                A_READ_WAIT: begin
                    if (bus_resp_valid_i) begin
                        state_q <= is_amo ? A_WRITE_REQ : A_RESP;
                    end
                end
                A_WRITE_REQ:  if (bus_ready_i) state_q <= A_WRITE_WAIT;
                A_WRITE_WAIT: if (bus_resp_valid_i) state_q <= A_RESP;
                A_RESP:       state_q <= A_IDLE;
                default:      state_q <= A_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == A_IDLE && dreq_valid_i) begin
            addr_q    <= dreq_addr_i;
            operand_q <= dreq_wdata_i;
            new_q     <= dreq_wdata_i;
            // Stores answer with zero
            old_q     <= '0;
        end else if (state_q == A_READ_WAIT && bus_resp_valid_i) begin
            old_q <= bus_resp_rdata_i;
            new_q <= amo_apply(op_q, bus_resp_rdata_i, operand_q);
        end
    end

    assign dreq_ready_o  = (state_q == A_IDLE);
    assign dresp_valid_o = (state_q == A_RESP);
    assign dresp_rdata_o = old_q;

    assign bus_valid_o = (state_q == A_READ_REQ) || (state_q == A_WRITE_REQ);
    assign bus_we_o    = (state_q == A_WRITE_REQ);
    assign bus_addr_o  = addr_q;
    assign bus_wdata_o = new_q;

    // Held from the accepted read until the write response
    assign lock_o = is_amo && ((state_q == A_READ_WAIT) || (state_q == A_WRITE_REQ) ||
                               (state_q == A_WRITE_WAIT));

endmodule

//--- logic/fetch_refill.sv
`timescale 1ns/1ps

module fetch_refill #(
    parameter int LINE_BEATS = 4
) (
    input  logic                          clk_i,
    input  logic                          rst_n_i,

    // Line fetch request and beat responses
    input  logic                          fetch_valid_i,
    output logic                          fetch_ready_o,
    input  logic [mem_pkg::ADDR_W-1:0]    fetch_paddr_i,
    output logic                          fetch_resp_valid_o,
    output logic [mem_pkg::DATA_W-1:0]    fetch_resp_data_o,
    output logic [$clog2(LINE_BEATS)-1:0] fetch_resp_beat_o,

    // Read-only requester port towards the arbiter
    output logic                          bus_valid_o,
    input  logic                          bus_ready_i,
    output logic [mem_pkg::ADDR_W-1:0]    bus_addr_o,
    input  logic                          bus_resp_valid_i,
    input  logic [mem_pkg::DATA_W-1:0]    bus_resp_rdata_i
);

    import mem_pkg::*;

    localparam int BEAT_W    = $clog2(LINE_BEATS);
    localparam int ROM_IDX_W = $clog2(BOOT_WORDS);
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(LINE_BEATS - 1);

    fetch_state_e          state_q;
    logic [BEAT_W-1:0]     beat_q;
    logic [ADDR_W-1:0]     line_addr_q;
    logic                  rom_valid_q;
    logic [BEAT_W-1:0]     rom_beat_q;
    logic [ROM_IDX_W-1:0]  rom_word;
    logic [DATA_W-1:0]     rom_data;
    logic                  boot_hit;

    assign boot_hit = (fetch_paddr_i < ADDR_W'(BOOT_LIMIT));
    assign rom_word = line_addr_q[2 +: ROM_IDX_W] + ROM_IDX_W'(beat_q);

    bootrom u_bootrom (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .rd_en_i   (state_q == F_BOOT),
        .rd_word_i (rom_word),
        .rd_data_o (rom_data)
    );

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= F_IDLE;
            beat_q      <= '0;
            rom_valid_q <= 1'b0;
            rom_beat_q  <= '0;
        end else begin
            // ROM data lags the read by one cycle, so the beat tag follows it
            rom_valid_q <= (state_q == F_BOOT);
            rom_beat_q  <= beat_q;
            case (state_q)
                F_IDLE: begin
                    if (fetch_valid_i) begin
                        beat_q  <= '0;
                        state_q <= boot_hit ? F_BOOT : F_BUS_REQ;
                    end
                end
                F_BOOT: begin
                    if (beat_q == LAST_BEAT) begin
                        beat_q  <= '0;
                        state_q <= F_IDLE;
                    end else begin
                        beat_q <= beat_q + 1'b1;
                    end
                end
                F_BUS_REQ: begin
                    if (bus_ready_i) begin
                        state_q <= F_BUS_WAIT;
                    end
                end
                F_BUS_WAIT: begin
                    if (bus_resp_valid_i) begin
                        if (beat_q == LAST_BEAT) begin
                            beat_q  <= '0;
                            state_q <= F_IDLE;
                        end else begin
                            beat_q  <= beat_q + 1'b1;
                            state_q <= F_BUS_REQ;
                        end
                    end
                end
                default: state_q <= F_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (fetch_valid_i && fetch_ready_o) begin
            line_addr_q <= fetch_paddr_i;
        end
    end

    assign fetch_ready_o = (state_q == F_IDLE);

    // Sequential word reads across the line
    assign bus_valid_o = (state_q == F_BUS_REQ);
    assign bus_addr_o  = line_addr_q + (ADDR_W'(beat_q) << 2);

    assign fetch_resp_valid_o = rom_valid_q || ((state_q == F_BUS_WAIT) && bus_resp_valid_i);
    assign fetch_resp_data_o  = rom_valid_q ? rom_data : bus_resp_rdata_i;
    assign fetch_resp_beat_o  = rom_valid_q ? rom_beat_q : beat_q;

endmodule

//--- logic/bootrom.sv
`timescale 1ns/1ps

module bootrom (
    input  logic                                   clk_i,
    input  logic                                   rst_n_i,
    input  logic                                   rd_en_i,
    input  logic [$clog2(mem_pkg::BOOT_WORDS)-1:0] rd_word_i,
    output logic [mem_pkg::DATA_W-1:0]             rd_data_o
);

    import mem_pkg::*;

    // Word held for one cycle after the read
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_data_o <= '0;
        end else if (rd_en_i) begin
            rd_data_o <= BOOT_IMAGE[rd_word_i];
        end
    end

endmodule

//--- logic/mem_pkg.sv
package mem_pkg;

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int BOOT_WORDS = 16;

    // Byte address where the boot region ends
    localparam int BOOT_LIMIT = 64;

    // Boot program image, one word per entry
    localparam logic [DATA_W-1:0] BOOT_IMAGE [BOOT_WORDS] = '{
        32'h0000_0093, 32'h0000_0113, 32'h0000_0193, 32'h0000_0213,
        32'h1000_02b7, 32'h0002_a303, 32'h0063_0393, 32'h0072_a023,
        32'h0040_0413, 32'hfff4_0413, 32'hfe04_1ee3, 32'h0010_0493,
        32'h0094_8533, 32'h00a2_a223, 32'h0000_006f, 32'hdead_beef
    };

    // Data-side opcodes
    typedef enum logic [2:0] {
        OP_LOAD,
        OP_STORE,
        OP_AMO_ADD,
        OP_AMO_SWAP,
        OP_AMO_AND,
        OP_AMO_OR,
        OP_AMO_MAX
    } mem_op_e;

    typedef enum logic [1:0] {
        F_IDLE,
        F_BOOT,
        F_BUS_REQ,
        F_BUS_WAIT
    } fetch_state_e;

    typedef enum logic [2:0] {
        A_IDLE,
        A_READ_REQ,
        A_READ_WAIT,
        A_WRITE_REQ,
        A_WRITE_WAIT,
        A_RESP
    } amo_state_e;

endpackage
